/* pkt_parser.f */
hw/parser_pkg.sv
hw/hdr_collector.sv
hw/eth_parser.sv
hw/ipv4_parser.sv
hw/pkt_parser.sv
verification/pkt_parser_asserts.sv
verification/pkt_parser_tb.sv

/* Bender.yml */
package:
  name: pkt_parser

sources:
  - files:
      - hw/parser_pkg.sv
      - hw/hdr_collector.sv
      - hw/eth_parser.sv
      - hw/ipv4_parser.sv
      - hw/pkt_parser.sv
  - target: test
    files:
      - verification/pkt_parser_asserts.sv
      - verification/pkt_parser_tb.sv

/* verification/pkt_parser_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_parser_tb;

	localparam int win = 8;
	localparam int wait_limit = 2000;

	logic clk = 1'b0;
	logic reset;
	parser_pkg::beat_t in_beat;
	logic in_valid;
	logic in_ready;
	parser_pkg::beat_t tcp_beat;
	logic tcp_valid;
	logic tcp_ready;
	parser_pkg::eth_hdr_ch_t eth_hdr;
	logic eth_hdr_ready;
	parser_pkg::ipv4_hdr_ch_t ipv4_hdr;
	logic ipv4_hdr_ready;

	parser_pkg::beat_t tx[$]; // beats waiting to be driven
	parser_pkg::eth_hdr_u exp_eth[$];
	parser_pkg::ipv4_hdr_u exp_ipv4[$];
	parser_pkg::beat_t exp_tcp[$];
	parser_pkg::eth_hdr_u got_eth[$];
	parser_pkg::ipv4_hdr_u got_ipv4[$];
	parser_pkg::beat_t got_tcp[$];
	int got_tcp_cyc[$];
	logic [7:0] pkt[$];

	int cyc = 0;
	int mark_cyc = 0;
	int built = 0;
	int accepted = 0;
	bit random_ready = 1'b0;
	int errors = 0;
	int test_errors = 0;
	int tests = 0;
	int tests_failed = 0;

	pkt_parser #(
		.WIN_BYTES(win)
	) UUT (
		.clk(clk),
		.reset(reset),
		.in_beat(in_beat),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.tcp_beat(tcp_beat),
		.tcp_valid(tcp_valid),
		.tcp_ready(tcp_ready),
		.eth_hdr(eth_hdr),
		.eth_hdr_ready(eth_hdr_ready),
		.ipv4_hdr(ipv4_hdr),
		.ipv4_hdr_ready(ipv4_hdr_ready)
	);

	always #2 clk = ~clk;

	// output monitors
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (reset) begin
			if (in_valid && in_ready)
				accepted++;
			if (tcp_valid && tcp_ready) begin
				got_tcp.push_back(tcp_beat);
				got_tcp_cyc.push_back(cyc);
			end
			if (eth_hdr.valid && eth_hdr_ready)
				got_eth.push_back(eth_hdr.hdr);
			if (ipv4_hdr.valid && ipv4_hdr_ready)
				got_ipv4.push_back(ipv4_hdr.hdr);
		end
	end

	always @(posedge clk) begin
		if (random_ready) begin
			tcp_ready <= ($urandom % 4) != 0;
			eth_hdr_ready <= ($urandom % 3) != 0;
			ipv4_hdr_ready <= ($urandom % 3) != 0;
		end else begin
			tcp_ready <= 1'b1;
			eth_hdr_ready <= 1'b1;
			ipv4_hdr_ready <= 1'b1;
		end
	end

	task automatic note_error();
		errors++;
		test_errors++;
	endtask

	task automatic compare_int(input string name, input string what, input int exp, input int act);
		if (act != exp) begin
			$display("[FAIL] %s %s: expected %0d, actual %0d", name, what, exp, act);
			note_error();
		end
	endtask

	task automatic compare_beat(input string name, input parser_pkg::beat_t exp,
			input parser_pkg::beat_t act);
		if (act !== exp) begin
			$display("[FAIL] %s tcp beat: expected %h sop %b eop %b, actual %h sop %b eop %b",
				name, exp.data, exp.sop, exp.eop, act.data, act.sop, act.eop);
			note_error();
		end
	endtask

	task automatic compare_eth(input string name, input parser_pkg::eth_hdr_u exp,
			input parser_pkg::eth_hdr_u act);
		if (act !== exp) begin
			$display("[FAIL] %s eth_hdr: expected %h, actual %h", name, exp, act);
			note_error();
		end
	endtask

	task automatic compare_ipv4(input string name, input parser_pkg::ipv4_hdr_u exp,
			input parser_pkg::ipv4_hdr_u act);
		if (act !== exp) begin
			$display("[FAIL] %s ipv4_hdr: expected %h, actual %h", name, exp, act);
			note_error();
		end
	endtask

	// network order, most significant byte first
	task automatic put_field(input logic [63:0] value, input int nbytes);
		for (int i = nbytes - 1; i >= 0; i--)
			pkt.push_back(value[i*8 +: 8]);
	endtask

	task automatic build_packet(input logic [15:0] eth_type, input logic [3:0] ihl,
			input logic [7:0] proto, input int len);
		parser_pkg::eth_hdr_u eth;
		parser_pkg::ipv4_hdr_u ip;
		parser_pkg::beat_t b;
		int nbeats;
		bit is_tcp;
		eth.fld.dst = {16'h02aa, 32'($urandom)};
		eth.fld.src = {16'h02bb, 32'($urandom)};
		eth.fld.eth_type = eth_type;
		ip.fld.version = 4'd4;
		ip.fld.ihl = ihl;
		ip.fld.tos = 8'h00;
		ip.fld.total_len = 16'(len - 14);
		ip.fld.id = 16'($urandom);
		ip.fld.frag_off = 16'h4000; // don't fragment
		ip.fld.ttl = 8'd64;
		ip.fld.proto = proto;
		ip.fld.checksum = 16'($urandom);
		ip.fld.src = $urandom;
		ip.fld.dst = $urandom;
		pkt.delete();
		put_field(eth.fld.dst, 6);
		put_field(eth.fld.src, 6);
		put_field(eth_type, 2);
		put_field({ip.fld.version, ihl}, 1);
		put_field(ip.fld.tos, 1);
		put_field(ip.fld.total_len, 2);
		put_field(ip.fld.id, 2);
		put_field(ip.fld.frag_off, 2);
		put_field(ip.fld.ttl, 1);
		put_field(proto, 1);
		put_field(ip.fld.checksum, 2);
		put_field(ip.fld.src, 4);
		put_field(ip.fld.dst, 4);
		while (pkt.size() < len)
			pkt.push_back(8'($urandom));
		exp_eth.push_back(eth);
		if (eth_type == 16'h0800)
			exp_ipv4.push_back(ip);
		is_tcp = (eth_type == 16'h0800) && (ihl == 4'd5) && (proto == 8'd6);
		nbeats = (len + win - 1) / win;
		built += nbeats;
		for (int i = 0; i < nbeats; i++) begin
			for (int j = 0; j < win; j++) begin
				if (i * win + j < len)
					b.data[j] = pkt[i * win + j];
				else
					b.data[j] = 8'h00; // pad of the last beat
			end
			b.sop = (i == 0);
			b.eop = (i == nbeats - 1);
			tx.push_back(b);
			// tcp segment starts at byte 34
			if (is_tcp && i >= 34 / win) begin
				b.sop = (i == 34 / win);
				exp_tcp.push_back(b);
			end
		end
	endtask

	// each beat is held until in_ready takes it
	task automatic send_beats(input int mark_beat);
		int n;
		int waited;
		n = 0;
		while (tx.size() > 0) begin
			in_beat <= tx.pop_front();
			in_valid <= 1'b1;
			waited = 0;
			do begin
				@(posedge clk);
				waited++;
			end while (!in_ready && waited < wait_limit);
			if (!in_ready) begin
				$display("timeout while waiting for the DUT to take input beat %0d", n);
				note_error();
			end
			if (n == mark_beat)
				mark_cyc = cyc;
			n++;
		end
		in_valid <= 1'b0;
	endtask

	task automatic finish_test(input string name, input bit check_latency);
		int waited;
		int quiet;
		waited = 0;
		quiet = 0;
		// all results in, then a quiet stretch that would show extras
		while ((got_tcp.size() < exp_tcp.size() || got_eth.size() < exp_eth.size() ||
				got_ipv4.size() < exp_ipv4.size() || quiet < 16) && waited < wait_limit) begin
			@(posedge clk);
			waited++;
			if (tcp_valid || eth_hdr.valid || ipv4_hdr.valid)
				quiet = 0;
			else
				quiet++;
		end
		if (waited >= wait_limit) begin
			$display("timeout while waiting for the results of %s", name);
			note_error();
		end
		compare_int(name, "input beats taken", built, accepted);
		compare_int(name, "tcp beat count", exp_tcp.size(), got_tcp.size());
		compare_int(name, "eth_hdr count", exp_eth.size(), got_eth.size());
		compare_int(name, "ipv4_hdr count", exp_ipv4.size(), got_ipv4.size());
		if (check_latency && got_tcp_cyc.size() > 0)
			compare_int(name, "tcp latency", 2, got_tcp_cyc[0] - mark_cyc);
		while (exp_tcp.size() > 0 && got_tcp.size() > 0)
			compare_beat(name, exp_tcp.pop_front(), got_tcp.pop_front());
		while (exp_eth.size() > 0 && got_eth.size() > 0)
			compare_eth(name, exp_eth.pop_front(), got_eth.pop_front());
		while (exp_ipv4.size() > 0 && got_ipv4.size() > 0)
			compare_ipv4(name, exp_ipv4.pop_front(), got_ipv4.pop_front());
		exp_tcp.delete();
		exp_eth.delete();
		exp_ipv4.delete();
		got_tcp.delete();
		got_eth.delete();
		got_ipv4.delete();
		got_tcp_cyc.delete();
		built = 0;
		accepted = 0;
		tests++;
		if (test_errors == 0) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic test_tcp_packet();
		build_packet(16'h0800, 4'd5, 8'd6, 80);
		send_beats(4);
		finish_test("tcp_packet", 1'b0);
	endtask

	task automatic test_non_ipv4();
		build_packet(16'h86dd, 4'd5, 8'd6, 72);
		build_packet(16'h0800, 4'd5, 8'd6, 64);
		send_beats(4);
		finish_test("non_ipv4", 1'b0);
	endtask

	task automatic test_dropped_ipv4();
		build_packet(16'h0800, 4'd5, 8'd17, 66); // udp
		build_packet(16'h0800, 4'd6, 8'd6, 70);
		send_beats(4);
		finish_test("dropped_ipv4", 1'b0);
	endtask

	task automatic test_back_to_back();
		build_packet(16'h0800, 4'd5, 8'd6, 80);
		build_packet(16'h0806, 4'd5, 8'd6, 60);
		build_packet(16'h0800, 4'd5, 8'd6, 100);
		build_packet(16'h0800, 4'd5, 8'd17, 64);
		build_packet(16'h0800, 4'd5, 8'd6, 45);
		build_packet(16'h0800, 4'd6, 8'd6, 90);
		send_beats(4);
		finish_test("back_to_back", 1'b1);
	endtask

	task automatic test_random_ready();
		random_ready <= 1'b1;
		for (int i = 0; i < 10; i++)
			build_packet(16'h0800, 4'd5, 8'd6, 40 + int'($urandom % 80));
		send_beats(4);
		finish_test("random_ready", 1'b0);
		random_ready <= 1'b0;
	endtask

	initial begin
		void'($urandom(32'hbf0cd5b7));
		reset = 1'b0;
		in_valid = 1'b0;
		in_beat = '0;
		tcp_ready = 1'b1;
		eth_hdr_ready = 1'b1;
		ipv4_hdr_ready = 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		test_tcp_packet();
		test_non_ipv4();
		test_dropped_ipv4();
		test_back_to_back();
		test_random_ready();
		$display("%0d tests, %0d failed, %0d check errors, %0d assertion errors",
			tests, tests_failed, errors, UUT.u_asserts.fails);
		if (errors == 0 && UUT.u_asserts.fails == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/pkt_parser_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_parser_asserts (
	input wire logic clk,
	input wire logic reset,
	input wire parser_pkg::beat_t tcp_beat,
	input wire logic tcp_valid,
	input wire logic tcp_ready,
	input wire parser_pkg::eth_hdr_ch_t eth_hdr,
	input wire logic eth_hdr_ready,
	input wire parser_pkg::ipv4_hdr_ch_t ipv4_hdr,
	input wire logic ipv4_hdr_ready
);

	int fails = 0;

	// stalled tcp beat stays put
	tcp_hold: assert property (@(posedge clk) disable iff (!reset)
		tcp_valid && !tcp_ready |=> tcp_valid && $stable(tcp_beat))
	else begin
		fails++;
		$error("tcp beat changed while tcp_ready was low");
	end

	eth_hold: assert property (@(posedge clk) disable iff (!reset)
		eth_hdr.valid && !eth_hdr_ready |=> eth_hdr.valid && $stable(eth_hdr.hdr))
	else begin
		fails++;
		$error("eth_hdr dropped or changed before eth_hdr_ready");
	end

	ipv4_hold: assert property (@(posedge clk) disable iff (!reset)
		ipv4_hdr.valid && !ipv4_hdr_ready |=> ipv4_hdr.valid && $stable(ipv4_hdr.hdr))
	else begin
		fails++;
		$error("ipv4_hdr dropped or changed before ipv4_hdr_ready");
	end

	// a reset edge clears every valid
	reset_idle: assert property (@(posedge clk)
		!reset |=> !tcp_valid && !eth_hdr.valid && !ipv4_hdr.valid)
	else begin
		fails++;
		$error("a valid output is high after a reset cycle");
	end

endmodule

bind pkt_parser pkt_parser_asserts u_asserts (
	.clk(clk),
	.reset(reset),
	.tcp_beat(tcp_beat),
	.tcp_valid(tcp_valid),
	.tcp_ready(tcp_ready),
	.eth_hdr(eth_hdr),
	.eth_hdr_ready(eth_hdr_ready),
	.ipv4_hdr(ipv4_hdr),
	.ipv4_hdr_ready(ipv4_hdr_ready)
);

`default_nettype wire

/* hw/pkt_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_parser #(
	parameter int WIN_BYTES = parser_pkg::win_bytes_default
) (
	input wire logic clk,
	input wire logic reset,

	input wire parser_pkg::beat_t in_beat,
	input wire logic in_valid,
	output logic in_ready,

	output parser_pkg::beat_t tcp_beat,
	output logic tcp_valid,
	input wire logic tcp_ready,

	output parser_pkg::eth_hdr_ch_t eth_hdr,
	input wire logic eth_hdr_ready,

	output parser_pkg::ipv4_hdr_ch_t ipv4_hdr,
	input wire logic ipv4_hdr_ready
);

	// ipv4 stream between the stages
	parser_pkg::beat_t ipv4_beat;
	logic ipv4_valid;
	logic ipv4_ready;

	eth_parser #(
		.WIN_BYTES(WIN_BYTES)
	) u_eth (
		.clk(clk),
		.reset(reset),
		.in_beat(in_beat),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_beat(ipv4_beat),
		.out_valid(ipv4_valid),
		.out_ready(ipv4_ready),
		.eth_hdr(eth_hdr),
		.hdr_ready(eth_hdr_ready)
	);

	ipv4_parser #(
		.WIN_BYTES(WIN_BYTES)
	) u_ipv4 (
		.clk(clk),
		.reset(reset),
		.in_beat(ipv4_beat),
		.in_valid(ipv4_valid),
		.in_ready(ipv4_ready),
		.out_beat(tcp_beat),
		.out_valid(tcp_valid),
		.out_ready(tcp_ready),
		.ipv4_hdr(ipv4_hdr),
		.hdr_ready(ipv4_hdr_ready)
	);

endmodule

`default_nettype wire

/* hw/ipv4_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module ipv4_parser #(
	parameter int WIN_BYTES = parser_pkg::win_bytes_default
) (
	input wire logic clk,
	input wire logic reset,
	input wire parser_pkg::beat_t in_beat,
	input wire logic in_valid,
	output logic in_ready,
	output parser_pkg::beat_t out_beat,
	output logic out_valid,
	input wire logic out_ready,
	output parser_pkg::ipv4_hdr_ch_t ipv4_hdr,
	input wire logic hdr_ready
);

	localparam logic [1:0] st_hdr = 2'd0;
	localparam logic [1:0] st_fwd = 2'd1;
	localparam logic [1:0] st_drop = 2'd2;

	localparam logic [3:0] ip_version = 4'd4;
	localparam logic [3:0] ihl_plain = 4'd5; // 20 bytes, no options

	// packet byte sitting in lane 0 of our sop beat
	localparam int stream_base = parser_pkg::ipv4_hdr_offset -
		(parser_pkg::ipv4_hdr_offset % WIN_BYTES);
	localparam int hdr_end = parser_pkg::ipv4_hdr_offset + parser_pkg::ipv4_hdr_len - 1;
	localparam bit split = ((parser_pkg::tcp_seg_offset - stream_base) / WIN_BYTES) !=
		((hdr_end - stream_base) / WIN_BYTES);

	logic [1:0] state;
	logic sop_pend; // tcp segment opens on the next beat
	logic hdr_valid;
	logic take;
	logic hdr_last;
	logic pass;
	logic fwd_now;
	logic [parser_pkg::ipv4_hdr_len*8-1:0] hdr_bytes;

	assign take = in_valid && in_ready;
	assign in_ready = (!out_valid || out_ready) && !hdr_valid;

	assign ipv4_hdr.valid = hdr_valid;
	assign ipv4_hdr.hdr = hdr_bytes;

	// only plain ipv4 carrying tcp goes on
	assign pass = (ipv4_hdr.hdr.fld.version == ip_version) &&
		(ipv4_hdr.hdr.fld.ihl == ihl_plain) &&
		(ipv4_hdr.hdr.fld.proto == parser_pkg::ipv4_proto_tcp);
	assign fwd_now = (state == st_fwd) || (state == st_hdr && hdr_last && pass && !split);

	hdr_collector #(
		.WIN_BYTES(WIN_BYTES),
		.HDR_OFFSET(parser_pkg::ipv4_hdr_offset % WIN_BYTES),
		.HDR_LEN(parser_pkg::ipv4_hdr_len)
	) u_collector (
		.clk(clk),
		.reset(reset),
		.beat(in_beat),
		.take(take),
		.hdr_bytes(hdr_bytes),
		.last(hdr_last)
	);

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= st_hdr;
			sop_pend <= 1'b0;
			out_valid <= 1'b0;
			hdr_valid <= 1'b0;
		end else begin
			if (out_ready)
				out_valid <= 1'b0;
			if (hdr_ready)
				hdr_valid <= 1'b0;
			if (take) begin
				if (fwd_now)
					out_valid <= 1'b1;
				case (state)
					st_hdr: begin
						if (hdr_last) begin
							hdr_valid <= 1'b1; // reported even when dropped
							sop_pend <= split;
							if (in_beat.eop)
								state <= st_hdr;
							else
								state <= pass ? st_fwd : st_drop;
						end
					end
					st_fwd: begin
						sop_pend <= 1'b0;
						if (in_beat.eop)
							state <= st_hdr;
					end
					default: begin
						if (in_beat.eop)
							state <= st_hdr;
					end
				endcase
			end
		end
	end

	// beats go out unaligned, the segment starts mid beat
	always_ff @(posedge clk) begin
		if (take && fwd_now) begin
			out_beat.data <= in_beat.data;
			out_beat.sop <= (state == st_hdr) || sop_pend;
			out_beat.eop <= in_beat.eop;
		end
	end

endmodule

`default_nettype wire

/* hw/eth_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_parser #(
	parameter int WIN_BYTES = parser_pkg::win_bytes_default
) (
	input wire logic clk,
	input wire logic reset,
	input wire parser_pkg::beat_t in_beat,
	input wire logic in_valid,
	output logic in_ready,
	output parser_pkg::beat_t out_beat,
	output logic out_valid,
	input wire logic out_ready,
	output parser_pkg::eth_hdr_ch_t eth_hdr,
	input wire logic hdr_ready
);

	localparam logic [1:0] st_hdr = 2'd0;
	localparam logic [1:0] st_fwd = 2'd1;
	localparam logic [1:0] st_drop = 2'd2; // rest of a non-ipv4 packet

	// set when the ipv4 header opens a fresh beat
	localparam bit split = (parser_pkg::ipv4_hdr_offset / WIN_BYTES) !=
		((parser_pkg::eth_hdr_len - 1) / WIN_BYTES);

	logic [1:0] state;
	logic sop_pend;
	logic hdr_valid;
	logic take;
	logic hdr_last;
	logic pass;
	logic fwd_now;
	logic [parser_pkg::eth_hdr_len*8-1:0] hdr_bytes;

	assign take = in_valid && in_ready;
	assign in_ready = (!out_valid || out_ready) && !hdr_valid;

	assign eth_hdr.valid = hdr_valid;
	assign eth_hdr.hdr = hdr_bytes;

	assign pass = (eth_hdr.hdr.fld.eth_type == parser_pkg::eth_type_ipv4);
	assign fwd_now = (state == st_fwd) || (state == st_hdr && hdr_last && pass && !split);

	hdr_collector #(
		.WIN_BYTES(WIN_BYTES),
		.HDR_OFFSET(0),
		.HDR_LEN(parser_pkg::eth_hdr_len)
	) u_collector (
		.clk(clk),
		.reset(reset),
		.beat(in_beat),
		.take(take),
		.hdr_bytes(hdr_bytes),
		.last(hdr_last)
	);

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= st_hdr;
			sop_pend <= 1'b0;
			out_valid <= 1'b0;
			hdr_valid <= 1'b0;
		end else begin
			if (out_ready)
				out_valid <= 1'b0;
			if (hdr_ready)
				hdr_valid <= 1'b0;
			if (take) begin
				if (fwd_now)
					out_valid <= 1'b1;
				case (state)
					st_hdr: begin
						if (hdr_last) begin
							hdr_valid <= 1'b1;
							sop_pend <= split;
							if (in_beat.eop)
								state <= st_hdr;
							else
								state <= pass ? st_fwd : st_drop;
						end
					end
					st_fwd: begin
						sop_pend <= 1'b0;
						if (in_beat.eop)
							state <= st_hdr;
					end
					default: begin
						if (in_beat.eop)
							state <= st_hdr;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take && fwd_now) begin
			out_beat.data <= in_beat.data;
			out_beat.sop <= (state == st_hdr) || sop_pend; // first ipv4 beat
			out_beat.eop <= in_beat.eop;
		end
	end

endmodule

`default_nettype wire

/* hw/hdr_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module hdr_collector #(
	parameter int WIN_BYTES = 8,
	parameter int HDR_OFFSET = 0,
	parameter int HDR_LEN = 14
) (
	input wire logic clk,
	input wire logic reset,
	input wire parser_pkg::beat_t beat,
	input wire logic take,
	output logic [HDR_LEN*8-1:0] hdr_bytes,
	output logic last
);

	localparam int last_beat = (HDR_OFFSET + HDR_LEN - 1) / WIN_BYTES;
	localparam int cnt_w = $clog2(last_beat + 2);

	logic [cnt_w-1:0] cnt; // beat index, saturates past the header
	logic [cnt_w-1:0] idx;
	logic [HDR_LEN*8-1:0] hdr_q;

	// a sop beat always starts at index 0
	assign idx = beat.sop ? '0 : cnt;
	assign last = (idx == cnt_w'(last_beat));

	always_ff @(posedge clk) begin
		if (!reset) begin
			cnt <= '0;
		end else if (take) begin
			if (beat.eop)
				cnt <= '0;
			else if (idx == cnt_w'(last_beat + 1))
				cnt <= idx;
			else
				cnt <= idx + 1'b1;
		end
	end

	// stored bytes, overlaid with the lanes of the beat being taken
	always_comb begin
		hdr_bytes = hdr_q;
		for (int i = 0; i < HDR_LEN; i++) begin
			if (take && idx == cnt_w'((HDR_OFFSET + i) / WIN_BYTES))
				hdr_bytes[(HDR_LEN - 1 - i)*8 +: 8] = beat.data[(HDR_OFFSET + i) % WIN_BYTES];
		end
	end

	always_ff @(posedge clk) begin
		hdr_q <= hdr_bytes;
	end

endmodule

`default_nettype wire

/* hw/parser_pkg.sv */
`default_nettype none

package parser_pkg;

	localparam int win_bytes_default = 8;

	localparam int eth_hdr_len = 14;
	localparam int ipv4_hdr_offset = 14;
	localparam int ipv4_hdr_len = 20; // no options
	localparam int tcp_seg_offset = 34;

	localparam logic [15:0] eth_type_ipv4 = 16'h0800;
	localparam logic [7:0] ipv4_proto_tcp = 8'd6;

	// one stream beat, data[0] is the first byte on the wire
	typedef struct packed {
		logic [0:win_bytes_default-1][7:0] data;
		logic sop;
		logic eop;
	} beat_t;

	typedef struct packed {
		logic [47:0] dst;
		logic [47:0] src;
		logic [15:0] eth_type;
	} eth_fields_t;

	typedef union packed {
		logic [0:eth_hdr_len-1][7:0] raw;
		eth_fields_t fld;
	} eth_hdr_u;

	// ipv4 fields in network order
	typedef struct packed {
		logic [3:0] version;
		logic [3:0] ihl; // in 32-bit words
		logic [7:0] tos;
		logic [15:0] total_len;
		logic [15:0] id;
		logic [15:0] frag_off; // flags in the top 3 bits
		logic [7:0] ttl;
		logic [7:0] proto;
		logic [15:0] checksum;
		logic [31:0] src;
		logic [31:0] dst;
	} ipv4_fields_t;

	typedef union packed {
		logic [0:ipv4_hdr_len-1][7:0] raw;
		ipv4_fields_t fld;
	} ipv4_hdr_u;

	typedef struct packed {
		logic valid;
		eth_hdr_u hdr;
	} eth_hdr_ch_t;

	typedef struct packed {
		logic valid;
		ipv4_hdr_u hdr;
	} ipv4_hdr_ch_t;

endpackage

`default_nettype wire
